/* common/uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// register port geometry.
`define UART_A_WIDTH 8
`define UART_D_WIDTH 32

// fifo sizes in entries.
`define UART_TX_DEPTH 16
`define UART_RX_DEPTH 16

`endif

/* common/uart_pkg.sv */
`default_nettype none

`include "uart_defines.svh"

package uart_pkg;

    typedef enum logic [1:0] {
        UART_REG_BAUD    = 2'd0,
        UART_REG_CTRL    = 2'd1,
        UART_REG_DATA_TX = 2'd2,
        UART_REG_DATA_RX = 2'd3
    } uart_reg_e;

    typedef struct packed {
        logic [`UART_D_WIDTH-2:0] rsvd;
        logic                     soft_rst_n;  // low holds the serial core in reset.
    } uart_ctrl_t;

    typedef struct packed {
        logic [`UART_D_WIDTH-10:0] rsvd;
        logic                      tx_space;   // transmit fifo can take a byte.
        logic [7:0]                tx_data;
    } uart_data_tx_t;

    typedef struct packed {
        logic [`UART_D_WIDTH-11:0] rsvd;
        logic                      frame_err;
        logic                      rx_valid;
        logic [7:0]                rx_data;
    } uart_data_rx_t;

    // one received frame as stored in the receive fifo.
    typedef struct packed {
        logic [7:0] data;
        logic       frame_err;
    } uart_rx_frame_t;

endpackage

`default_nettype wire

/* source/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire payload_t in_data_i,
    input  wire logic     in_valid_i,
    output logic          in_ready_o,
    output payload_t      out_data_o,
    output logic          out_valid_o,
    input  wire logic     out_ready_i
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t       mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    logic           push;
    logic           pop;

    assign in_ready_o  = (count != (AW+1)'(DEPTH));
    assign out_valid_o = (count != '0);
    assign out_data_o  = mem[rd_ptr];
    assign push        = in_valid_i & in_ready_o;
    assign pop         = out_valid_o & out_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic [31:0] baud_div_i,
    input  wire logic [7:0]  data_i,
    input  wire logic        valid_i,
    output logic             ready_o,
    output logic             tx_o
);

    typedef enum logic {
        TX_IDLE,
        TX_SHIFT
    } tx_state_e;

    tx_state_e   state;
    logic [31:0] baud_cnt;
    logic [3:0]  bit_cnt;
    logic [9:0]  shift_q;
    logic        bit_end;

    assign ready_o = (state == TX_IDLE);
    assign tx_o    = shift_q[0];  // all ones while idle.
    // a divisor lowered mid-bit ends the current bit at once.
    assign bit_end = (baud_cnt >= baud_div_i - 32'd1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shift_q  <= '1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (valid_i) begin
                        shift_q  <= {1'b1, data_i, 1'b0};  // stop, data lsb first, start.
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= TX_SHIFT;
                    end
                end
                default: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        shift_q  <= {1'b1, shift_q[9:1]};
                        if (bit_cnt == 4'd9) begin
                            state <= TX_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 32'd1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic [31:0] baud_div_i,
    input  wire logic        rx_i,
    output uart_rx_frame_t   frame_o,
    output logic             valid_o
);

    typedef enum logic {
        RX_IDLE,
        RX_RECV
    } rx_state_e;

    rx_state_e   state;
    logic [1:0]  rx_sync;
    logic        rx_prev;
    logic        rx_s;
    logic        start_edge;
    logic [31:0] baud_cnt;
    logic [31:0] bit_len;
    logic [3:0]  bit_cnt;
    logic [7:0]  data_q;
    logic        sample;

    assign rx_s       = rx_sync[1];
    assign start_edge = rx_prev & ~rx_s;
    // the start bit is sampled after half a period, every later bit a full one after.
    assign bit_len    = (bit_cnt == 4'd0) ? (baud_div_i >> 1) : baud_div_i;
    assign sample     = (state == RX_RECV) && (baud_cnt == bit_len - 32'd1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_sync  <= 2'b11;
            rx_prev  <= 1'b1;
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_o  <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx_i};
            rx_prev <= rx_s;
            valid_o <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (start_edge) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= RX_RECV;
                    end
                end
                default: begin
                    if (sample) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd0 && rx_s) begin
                            state <= RX_IDLE;  // glitch, not a start bit.
                        end else if (bit_cnt == 4'd9) begin
                            valid_o <= 1'b1;
                            state   <= RX_IDLE;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 32'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            data_q <= {rx_s, data_q[7:1]};
        end
        if (sample && bit_cnt == 4'd9) begin
            frame_o.data      <= data_q;
            frame_o.frame_err <= ~rx_s;  // stop bit must be high.
        end
    end

endmodule

`default_nettype wire

/* uart/uart.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart import uart_pkg::*; (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic [31:0]    baud_div_i,
    input  wire logic [7:0]     in_data_i,
    input  wire logic           in_valid_i,
    output logic                in_ready_o,
    output uart_rx_frame_t      out_data_o,
    output logic                out_valid_o,
    input  wire logic           out_ready_i,
    input  wire logic           rx_i,
    output logic                tx_o
);

    logic [7:0]     tx_byte;
    logic           tx_byte_valid;
    logic           tx_byte_ready;
    uart_rx_frame_t rx_frame;
    logic           rx_frame_valid;
    logic           rx_fifo_ready;
    logic           rx_push;

    assign rx_push = rx_frame_valid & rx_fifo_ready;  // a frame is lost when the fifo is full.

    sync_fifo #(
        .payload_t (logic [7:0]),
        .DEPTH     (`UART_TX_DEPTH)
    ) u_tx_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_data_o  (tx_byte),
        .out_valid_o (tx_byte_valid),
        .out_ready_i (tx_byte_ready)
    );

    uart_tx u_uart_tx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .baud_div_i (baud_div_i),
        .data_i     (tx_byte),
        .valid_i    (tx_byte_valid),
        .ready_o    (tx_byte_ready),
        .tx_o       (tx_o)
    );

    uart_rx u_uart_rx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .baud_div_i (baud_div_i),
        .rx_i       (rx_i),
        .frame_o    (rx_frame),
        .valid_o    (rx_frame_valid)
    );

    sync_fifo #(
        .payload_t (uart_rx_frame_t),
        .DEPTH     (`UART_RX_DEPTH)
    ) u_rx_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_data_i   (rx_frame),
        .in_valid_i  (rx_push),
        .in_ready_o  (rx_fifo_ready),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

`default_nettype wire

/* source/mmio_uart.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module mmio_uart import uart_pkg::*; (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire logic                     wr_en_i,
    input  wire logic [`UART_A_WIDTH-1:0] wr_addr_i,
    input  wire logic [`UART_D_WIDTH-1:0] wr_data_i,
    input  wire logic                     rd_en_i,
    input  wire logic [`UART_A_WIDTH-1:0] rd_addr_i,
    output logic      [`UART_D_WIDTH-1:0] rd_data_o,
    input  wire logic                     rx_i,
    output logic                          tx_o
);

    logic [`UART_D_WIDTH-1:0] baud_q;
    uart_ctrl_t               ctrl_q;
    logic [7:0]               tx_data;
    logic                     tx_valid;
    logic                     tx_ready;
    uart_rx_frame_t           rx_frame;
    logic                     rx_valid;
    logic                     rx_ready;
    logic                     core_rst_n;
    logic                     wr_tx_hit;
    logic                     rd_rx_hit;
    uart_data_tx_t            tx_view;
    uart_data_rx_t            rx_view;
    logic [`UART_D_WIDTH-1:0] rd_view;

    assign core_rst_n = rst_n_i & ctrl_q.soft_rst_n;
    assign wr_tx_hit  = wr_en_i && (wr_addr_i[3:2] == UART_REG_DATA_TX);
    assign rd_rx_hit  = rd_en_i && (rd_addr_i[3:2] == UART_REG_DATA_RX);

    always_comb begin
        tx_view           = '0;
        tx_view.tx_space  = tx_ready;
        tx_view.tx_data   = tx_data;
        rx_view           = '0;
        rx_view.frame_err = rx_frame.frame_err;
        rx_view.rx_valid  = rx_valid;
        rx_view.rx_data   = rx_frame.data;
    end

    always_comb begin
        case (uart_reg_e'(rd_addr_i[3:2]))
            UART_REG_BAUD:    rd_view = baud_q;
            UART_REG_CTRL:    rd_view = ctrl_q;
            UART_REG_DATA_TX: rd_view = tx_view;
            default:          rd_view = rx_view;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            baud_q    <= '0;
            ctrl_q    <= '0;
            tx_data   <= '0;
            tx_valid  <= 1'b0;
            rd_data_o <= '0;
        end else begin
            if (rd_en_i) begin
                rd_data_o <= rd_view;
            end
            if (wr_en_i && (wr_addr_i[3:2] == UART_REG_BAUD)) begin
                baud_q <= wr_data_i;
            end
            if (wr_en_i && (wr_addr_i[3:2] == UART_REG_CTRL)) begin
                ctrl_q.soft_rst_n <= wr_data_i[0];
            end
            if (wr_tx_hit) begin
                tx_data  <= wr_data_i[7:0];  // a pending byte is overwritten.
                tx_valid <= 1'b1;
            end else if (tx_ready) begin
                tx_valid <= 1'b0;
            end
        end
    end

    // pop the head entry once, on the cycle after it was returned.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= rd_rx_hit & rx_valid & ~rx_ready;
        end
    end

    uart u_uart (
        .clk_i       (clk_i),
        .rst_n_i     (core_rst_n),
        .baud_div_i  (baud_q),
        .in_data_i   (tx_data),
        .in_valid_i  (tx_valid),
        .in_ready_o  (tx_ready),
        .out_data_o  (rx_frame),
        .out_valid_o (rx_valid),
        .out_ready_i (rx_ready),
        .rx_i        (rx_i),
        .tx_o        (tx_o)
    );

endmodule

`default_nettype wire

/* bench/tb_mmio_uart.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module tb_mmio_uart import uart_pkg::*; ;

    localparam logic [7:0] A_BAUD    = 8'h00;
    localparam logic [7:0] A_CTRL    = 8'h04;
    localparam logic [7:0] A_TX      = 8'h08;
    localparam logic [7:0] A_RX      = 8'h0c;
    localparam int         N_STIM    = 8;
    localparam int         MAX_DIV   = 32;
    localparam int         POLL_MAX  = 400;
    localparam int         BP_COUNT  = `UART_TX_DEPTH + 2;
    localparam int         BP_EXPECT = (BP_COUNT < `UART_RX_DEPTH) ? BP_COUNT : `UART_RX_DEPTH;
    localparam longint     MARGIN_NS = 2 * (BP_COUNT + 4) * 10 * MAX_DIV * 40 + 100_000;

    typedef struct packed {
        logic [7:0] data;
        logic [7:0] div;
        logic       stop;
        logic       rnd;   // data is taken from the lcg.
    } stim_t;

    logic        clk_i;
    logic        rst_n_i;
    logic        wr_en_i;
    logic [7:0]  wr_addr_i;
    logic [31:0] wr_data_i;
    logic        rd_en_i;
    logic [7:0]  rd_addr_i;
    logic [31:0] rd_data_o;
    logic        rx_line;
    logic        tx_o;
    logic        loop_en;
    logic        drv_line;
    logic [31:0] lcg_state;
    int          errors;
    stim_t       stim [N_STIM];

    assign rx_line = loop_en ? tx_o : drv_line;

    always #20 clk_i = ~clk_i;

    mmio_uart u_mmio_uart (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o),
        .rx_i      (rx_line),
        .tx_o      (tx_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk_i);
        wr_en_i   = 1'b1;
        wr_addr_i = addr;
        wr_data_i = data;
        @(negedge clk_i);
        wr_en_i   = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk_i);
        rd_en_i   = 1'b1;
        rd_addr_i = addr;
        @(negedge clk_i);
        rd_en_i   = 1'b0;
        @(negedge clk_i);  // the pop after a DATA_RX read lands here.
        data      = rd_data_o;
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop, input int div);
        logic [9:0] bits;
        bits = {stop, data, 1'b0};
        @(negedge clk_i);
        for (int b = 0; b < 10; b++) begin
            drv_line = bits[b];
            repeat (div) @(negedge clk_i);
        end
        drv_line = 1'b1;
        repeat (div) @(negedge clk_i);
    endtask

    // polls DATA_RX for one frame, checks it, then checks that it was popped.
    task automatic expect_frame(input logic [7:0] data, input logic ferr);
        logic [31:0]   word;
        uart_data_rx_t rx_word;
        int            polls;
        polls   = 0;
        rx_word = '0;
        while (!rx_word.rx_valid && polls < POLL_MAX) begin
            bus_read(A_RX, word);
            rx_word = word;
            polls++;
        end
        if (!rx_word.rx_valid) begin
            $display("ERROR at %0t ns: no frame reached DATA_RX after %0d reads", $time, polls);
            errors++;
        end else begin
            check("rx_data", data, rx_word.rx_data);
            check("frame_err", ferr, rx_word.frame_err);
            bus_read(A_RX, word);
            rx_word = word;
            check("rx_valid after pop", 0, rx_word.rx_valid);
        end
    endtask

    task automatic loop_byte(input logic [7:0] data);
        bus_write(A_TX, {24'h0, data});
        expect_frame(data, 1'b0);
    endtask

    initial begin : main_seq
        logic [31:0]   word;
        uart_data_rx_t rx_word;
        uart_data_tx_t tx_word;
        logic [7:0]    bp_bytes [BP_COUNT];
        int            n;
        logic          tx_low;
        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        wr_en_i   = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        rd_en_i   = 1'b0;
        rd_addr_i = '0;
        loop_en   = 1'b1;
        drv_line  = 1'b1;
        errors    = 0;
        lcg_state = 32'hf032_0d54;
        stim[0]   = {8'h00, 8'd4,  1'b1, 1'b0};
        stim[1]   = {8'hff, 8'd5,  1'b1, 1'b0};
        stim[2]   = {8'h00, 8'd8,  1'b1, 1'b1};
        stim[3]   = {8'ha5, 8'd16, 1'b0, 1'b0};
        stim[4]   = {8'h00, 8'd6,  1'b1, 1'b1};
        stim[5]   = {8'h00, 8'd32, 1'b1, 1'b1};
        stim[6]   = {8'h00, 8'd11, 1'b0, 1'b1};
        stim[7]   = {8'h55, 8'd4,  1'b1, 1'b0};
        for (int i = 0; i < N_STIM; i++) begin
            if (stim[i].rnd) begin
                lcg_state    = lcg_next(lcg_state);
                stim[i].data = lcg_state[23:16];
            end
        end
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;

        bus_read(A_BAUD, word);
        check("baud after reset", 32'h0, word);
        bus_read(A_CTRL, word);
        check("ctrl after reset", 32'h0, word);
        check("tx_o after reset", 1, tx_o);
        bus_write(A_BAUD, 32'h5a5a_0010);
        bus_read(A_BAUD, word);
        check("baud readback", 32'h5a5a_0010, word);
        bus_write(A_CTRL, 32'h1);
        bus_read(A_CTRL, word);
        check("ctrl soft_rst_n readback", 1, word[0]);

        for (int i = 0; i < N_STIM; i++) begin
            bus_write(A_BAUD, 32'(stim[i].div));
            if (stim[i].stop) begin
                loop_byte(stim[i].data);
            end else begin
                loop_en = 1'b0;  // the bench drives the receive line itself.
                send_frame(stim[i].data, 1'b0, int'(stim[i].div));
                expect_frame(stim[i].data, 1'b1);
                send_frame(~stim[i].data, 1'b1, int'(stim[i].div));
                expect_frame(~stim[i].data, 1'b0);
                loop_en = 1'b1;
            end
        end

        bus_write(A_BAUD, MAX_DIV);
        for (int k = 0; k < BP_COUNT; k++) begin
            lcg_state   = lcg_next(lcg_state);
            bp_bytes[k] = lcg_state[23:16];
            bus_write(A_TX, {24'h0, bp_bytes[k]});
        end
        bus_read(A_TX, word);
        tx_word = word;
        check("tx_space with full fifo", 0, tx_word.tx_space);
        repeat (BP_COUNT * 10 * MAX_DIV + 4 * MAX_DIV) @(negedge clk_i);
        bus_read(A_TX, word);
        tx_word = word;
        check("tx_space after burst", 1, tx_word.tx_space);
        n = 0;
        bus_read(A_RX, word);
        rx_word = word;
        while (rx_word.rx_valid && n < BP_COUNT) begin
            check("rx_data in burst", bp_bytes[n], rx_word.rx_data);
            n++;
            bus_read(A_RX, word);
            rx_word = word;
        end
        check("frames kept from burst", BP_EXPECT, n);

        bus_write(A_BAUD, 32'd8);
        bus_write(A_TX, 32'h0000_0096);  // this frame waits in the receive fifo.
        bus_write(A_TX, 32'h0000_00c3);
        repeat (13 * 8) @(negedge clk_i);  // cut the second frame in its data bits.
        bus_write(A_CTRL, 32'h0);
        tx_low = 1'b0;
        repeat (10 * 8) begin
            @(negedge clk_i);
            if (!tx_o) begin
                tx_low = 1'b1;
            end
        end
        check("tx_o low in soft reset", 0, tx_low);
        bus_read(A_RX, word);
        rx_word = word;
        check("rx_valid in soft reset", 0, rx_word.rx_valid);
        bus_write(A_CTRL, 32'h1);
        loop_byte(8'h3c);

        $display("all checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // the limit follows the frame time of the table plus the burst test.
    initial begin : watchdog
        longint limit_ns;
        @(posedge rst_n_i);
        limit_ns = 0;
        for (int i = 0; i < N_STIM; i++) begin
            limit_ns += 10 * stim[i].div * 40;
        end
        limit_ns = 2 * limit_ns + MARGIN_NS;
        #(limit_ns);
        $display("ERROR: the run did not finish within %0d ns and was stopped", limit_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/uart_pkg.sv
source/sync_fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart.sv
source/mmio_uart.sv
bench/tb_mmio_uart.sv
